//--- hdl/perf_settings.svh
`ifndef PERF_SETTINGS_SVH
`define PERF_SETTINGS_SVH

// datapath widths
`define PERF_CTR_W          64
`define PERF_WORD_W         32
`define PERF_TAG_W          20
`define PERF_PHASE_W        32
`define PERF_ADDR_W         5      // comm_i[4:0] read address

// event counter bank
`define PERF_NUM_EVENTS     10

// reuse sampler table
`define PERF_SAMPLE_DEPTH   4
`define PERF_SAMPLE_IDX_W   2      // log2 of the table depth
`define PERF_SAMPLE_CNT_W   3      // holds 0..depth
`define PERF_RATE_W         4

// command word fields
`define PERF_COUNT_EN_BIT   24

// returned at stats address 15
`define PERF_CACHE_ID       32'h1ea5_0002

`endif

//--- hdl/perf_pkg.sv
`include "perf_settings.svh"

package perf_pkg;

	typedef logic [`PERF_CTR_W-1:0]  ctr_t;	// one event counter
	typedef logic [`PERF_WORD_W-1:0] word_t;	// one readback word

	// counter index inside the event bank
	typedef enum logic [3:0] {
		EV_HIT           = 4'd0,
		EV_MISS          = 4'd1,
		EV_WRITEBACK     = 4'd2,
		EV_EXPIRED       = 4'd3,
		EV_EXPIRED_MULTI = 4'd4,
		EV_DEFAULTED     = 4'd5,
		EV_RAND_EVICT    = 4'd6,
		EV_DEFAULT_MISS  = 4'd7,
		EV_ZERO_LEASE    = 4'd8,
		EV_WALLTIME      = 4'd9
	} perf_event_e;

	typedef enum logic {
		BANK_STATS   = 1'b0,
		BANK_SAMPLER = 1'b1
	} bank_e;

	// one reuse sampler slot
	typedef struct packed {
		logic                   valid;
		logic [`PERF_TAG_W-1:0] tag;
		word_t                  pc;	// phase byte and low pc bits
		word_t                  stamp;	// request count at allocation
	} sample_entry_t;

endpackage

//--- hdl/perf_cmd_decode.sv
`timescale 1ns/100ps
`include "perf_settings.svh"

module perf_cmd_decode
	import perf_pkg::*;
(
	input  word_t                   comm_i,
	input  logic [1:0]              select_i,
	output logic                    count_en_o,
	output bank_e                   bank_o,
	output logic                    bank_valid_o,
	output logic [`PERF_ADDR_W-1:0] addr_o,
	output logic                    sampler_en_o
);

	logic sel_stats;
	logic sel_sampler;

	// select_i 1x is reserved and reads back zero
	assign sel_stats   = (select_i == 2'b00);
	assign sel_sampler = (select_i == 2'b01);

	always_comb begin
		count_en_o   = comm_i[`PERF_COUNT_EN_BIT];	// global count enable
		addr_o       = comm_i[`PERF_ADDR_W-1:0];
		bank_valid_o = sel_stats | sel_sampler;
		sampler_en_o = sel_sampler;	// sampler only runs while its bank is selected
		if (sel_sampler) begin
			bank_o = BANK_SAMPLER;
		end else begin
			bank_o = BANK_STATS;	// also the default for the reserved codes
		end
	end

endmodule

//--- hdl/perf_event_counters.sv
`timescale 1ns/100ps
`include "perf_settings.svh"

module perf_event_counters
	import perf_pkg::*;
(
	input  logic                    clock_i,
	input  logic                    resetn_i,
	input  logic                    count_en_i,
	input  logic                    hit_i,
	input  logic                    miss_i,
	input  logic                    writeback_i,
	input  logic                    expired_i,
	input  logic                    expired_multi_i,
	input  logic                    defaulted_i,
	input  logic                    rand_evict_i,
	input  logic                    swap_i,
	input  logic [`PERF_ADDR_W-1:0] addr_i,
	output word_t                   rd_word_o
);

	ctr_t                        ctr_q [`PERF_NUM_EVENTS];
	logic                        swap_q;	// swap_i at the last enabled edge
	logic [`PERF_NUM_EVENTS-1:0] ev_vec;
	perf_event_e                 rd_sel;
	logic                        rd_hit;
	ctr_t                        rd_ctr;

	always_comb begin
		ev_vec                   = '0;
		ev_vec[EV_HIT]           = hit_i;
		ev_vec[EV_MISS]          = miss_i;
		ev_vec[EV_WRITEBACK]     = writeback_i;
		ev_vec[EV_EXPIRED]       = expired_i;
		ev_vec[EV_EXPIRED_MULTI] = expired_multi_i;
		ev_vec[EV_DEFAULTED]     = defaulted_i;
		ev_vec[EV_RAND_EVICT]    = rand_evict_i;
		ev_vec[EV_DEFAULT_MISS]  = miss_i & defaulted_i;	// miss caused by a default lease
		ev_vec[EV_ZERO_LEASE]    = swap_q & ~swap_i;	// falling edge of swap
		ev_vec[EV_WALLTIME]      = 1'b1;	// cycles while enabled
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			swap_q <= 1'b0;
			for (int i = 0; i < `PERF_NUM_EVENTS; i++) begin
				ctr_q[i] <= '0;
			end
		end else if (count_en_i) begin
			swap_q <= swap_i;
			for (int i = 0; i < `PERF_NUM_EVENTS; i++) begin
				if (ev_vec[i]) begin
					ctr_q[i] <= ctr_q[i] + ctr_t'(1);
				end
			end
		end
	end

	// stats read map, each counter as a low/high word pair
	always_comb begin
		rd_hit = 1'b1;
		case (addr_i[`PERF_ADDR_W-1:1])
			4'd0:    rd_sel = EV_HIT;
			4'd1:    rd_sel = EV_MISS;
			4'd2:    rd_sel = EV_WRITEBACK;
			4'd3:    rd_sel = EV_WALLTIME;
			4'd4:    rd_sel = EV_EXPIRED;
			4'd5:    rd_sel = EV_DEFAULTED;
			4'd6:    rd_sel = EV_EXPIRED_MULTI;
			4'd8:    rd_sel = EV_ZERO_LEASE;
			4'd9:    rd_sel = EV_RAND_EVICT;
			4'd10:   rd_sel = EV_DEFAULT_MISS;
			default: begin
				rd_sel = EV_HIT;
				rd_hit = 1'b0;	// unmapped pair
			end
		endcase
		rd_ctr = ctr_q[rd_sel];
		if (addr_i == `PERF_ADDR_W'(15)) begin
			rd_word_o = `PERF_CACHE_ID;
		end else if (!rd_hit) begin
			rd_word_o = '0;
		end else if (addr_i[0]) begin
			rd_word_o = rd_ctr[`PERF_CTR_W-1:`PERF_WORD_W];
		end else begin
			rd_word_o = rd_ctr[`PERF_WORD_W-1:0];
		end
	end

endmodule

//--- hdl/reuse_sampler.sv
`timescale 1ns/100ps
`include "perf_settings.svh"

module reuse_sampler
	import perf_pkg::*;
(
	input  logic                    clock_i,
	input  logic                    resetn_i,
	input  logic                    en_i,
	input  logic                    req_i,
	input  word_t                   pc_i,
	input  logic [`PERF_TAG_W-1:0]  tag_i,
	input  logic [`PERF_RATE_W-1:0] rate_i,
	input  logic [`PERF_ADDR_W-1:0] addr_i,
	output logic                    full_o,
	output word_t                   rd_word_o
);

	sample_entry_t                 table_q [`PERF_SAMPLE_DEPTH];
	word_t                         req_count_q;
	word_t                         last_interval_q;
	word_t                         last_pc_q;
	word_t                         measured_count_q;
	logic                          hit_found;
	logic [`PERF_SAMPLE_IDX_W-1:0] hit_idx;
	logic                          free_found;
	logic [`PERF_SAMPLE_IDX_W-1:0] free_idx;
	logic [`PERF_SAMPLE_CNT_W-1:0] occupancy;
	word_t                         rate_mask;
	logic                          sample_due;

	// table lookup, walk downwards so the lowest slot wins
	always_comb begin
		hit_found  = 1'b0;
		hit_idx    = '0;
		free_found = 1'b0;
		free_idx   = '0;
		occupancy  = '0;
		for (int i = `PERF_SAMPLE_DEPTH - 1; i >= 0; i--) begin
			if (table_q[i].valid) begin
				occupancy = occupancy + `PERF_SAMPLE_CNT_W'(1);
				if (table_q[i].tag == tag_i) begin
					hit_found = 1'b1;
					hit_idx   = `PERF_SAMPLE_IDX_W'(i);
				end
			end else begin
				free_found = 1'b1;
				free_idx   = `PERF_SAMPLE_IDX_W'(i);
			end
		end
	end

	assign rate_mask  = (word_t'(1) << rate_i) - word_t'(1);	// low rate_i bits
	assign sample_due = ((req_count_q & rate_mask) == '0);
	assign full_o     = !free_found;	// every slot holds a sample

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			req_count_q      <= '0;
			last_interval_q  <= '0;
			last_pc_q        <= '0;
			measured_count_q <= '0;
			for (int i = 0; i < `PERF_SAMPLE_DEPTH; i++) begin
				table_q[i] <= '0;
			end
		end else if (en_i && req_i) begin
			req_count_q <= req_count_q + word_t'(1);
			if (hit_found) begin	// reuse seen, close the interval
				table_q[hit_idx].valid <= 1'b0;
				last_interval_q        <= req_count_q - table_q[hit_idx].stamp;
				last_pc_q              <= table_q[hit_idx].pc;
				measured_count_q       <= measured_count_q + word_t'(1);
			end else if (sample_due && free_found) begin
				table_q[free_idx].valid <= 1'b1;
				table_q[free_idx].tag   <= tag_i;
				table_q[free_idx].pc    <= pc_i;
				table_q[free_idx].stamp <= req_count_q;
			end
		end
	end

	always_comb begin
		case (addr_i)
			`PERF_ADDR_W'(0): rd_word_o = last_interval_q;
			`PERF_ADDR_W'(1): rd_word_o = last_pc_q;
			`PERF_ADDR_W'(2): rd_word_o = measured_count_q;
			`PERF_ADDR_W'(3): rd_word_o = word_t'(occupancy);
			`PERF_ADDR_W'(4): rd_word_o = word_t'(full_o);
			`PERF_ADDR_W'(5): rd_word_o = req_count_q;
			default:          rd_word_o = '0;
		endcase
	end

endmodule

//--- hdl/perf_readout.sv
`timescale 1ns/100ps

module perf_readout
	import perf_pkg::*;
(
	input  logic  clock_i,
	input  logic  resetn_i,
	input  bank_e bank_i,
	input  logic  bank_valid_i,
	input  word_t stats_word_i,
	input  word_t sample_word_i,
	output word_t comm_o
);

	word_t sel_word;
	word_t comm_q;

	// pick the word for the selected bank
	always_comb begin
		if (!bank_valid_i) begin
			sel_word = '0;	// reserved select codes
		end else begin
			case (bank_i)
				BANK_SAMPLER: sel_word = sample_word_i;
				default:      sel_word = stats_word_i;
			endcase
		end
	end

	// one register stage between the banks and the comm port
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			comm_q <= '0;
		end else begin
			comm_q <= sel_word;
		end
	end

	assign comm_o = comm_q;

endmodule

//--- hdl/cache_perf_monitor.sv
`timescale 1ns/100ps
`include "perf_settings.svh"

module cache_perf_monitor
	import perf_pkg::*;
(
	input  logic                     clock_i,
	input  logic                     resetn_i,
	input  logic                     hit_i,
	input  logic                     miss_i,
	input  logic                     writeback_i,
	input  logic                     expired_i,
	input  logic                     expired_multi_i,
	input  logic                     defaulted_i,
	input  logic                     rand_evict_i,
	input  logic                     swap_i,
	input  logic                     req_i,
	input  word_t                    pc_i,
	input  logic [`PERF_PHASE_W-1:0] phase_i,
	input  logic [`PERF_TAG_W-1:0]   tag_i,
	input  word_t                    comm_i,
	input  logic [1:0]               select_i,
	input  logic [`PERF_RATE_W-1:0]  rate_i,
	output word_t                    comm_o,
	output logic                     stall_o
);

	logic                    count_en;
	bank_e                   bank;
	logic                    bank_valid;
	logic [`PERF_ADDR_W-1:0] addr;
	logic                    sampler_en;
	logic                    sampler_full;
	word_t                   stats_word;
	word_t                   sample_word;
	word_t                   sampler_pc;

	assign sampler_pc = {phase_i[7:0], pc_i[23:0]};	// phase byte tags the pc
	assign stall_o    = sampler_en & sampler_full;

	perf_cmd_decode i_perf_cmd_decode (
		.comm_i       (comm_i),
		.select_i     (select_i),
		.count_en_o   (count_en),
		.bank_o       (bank),
		.bank_valid_o (bank_valid),
		.addr_o       (addr),
		.sampler_en_o (sampler_en)
	);

	perf_event_counters i_perf_event_counters (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.count_en_i      (count_en),
		.hit_i           (hit_i),
		.miss_i          (miss_i),
		.writeback_i     (writeback_i),
		.expired_i       (expired_i),
		.expired_multi_i (expired_multi_i),
		.defaulted_i     (defaulted_i),
		.rand_evict_i    (rand_evict_i),
		.swap_i          (swap_i),
		.addr_i          (addr),
		.rd_word_o       (stats_word)
	);

	reuse_sampler i_reuse_sampler (
		.clock_i   (clock_i),
		.resetn_i  (resetn_i),
		.en_i      (sampler_en),
		.req_i     (req_i),
		.pc_i      (sampler_pc),
		.tag_i     (tag_i),
		.rate_i    (rate_i),
		.addr_i    (addr),
		.full_o    (sampler_full),
		.rd_word_o (sample_word)
	);

	perf_readout i_perf_readout (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.bank_i        (bank),
		.bank_valid_i  (bank_valid),
		.stats_word_i  (stats_word),
		.sample_word_i (sample_word),
		.comm_o        (comm_o)
	);

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clock_o,
	output logic resetn_o
);

	initial begin
		clock_o = 1'b0;
		forever #2 clock_o = ~clock_o;	// 4 ns period
	end

	initial begin
		resetn_o = 1'b0;
		repeat (4) @(posedge clock_o);
		@(negedge clock_o);
		resetn_o = 1'b1;	// release between rising edges
	end

endmodule

//--- tests/perf_assertions.sv
`timescale 1ns/100ps
`include "perf_settings.svh"

module perf_assertions (
	input logic                    clock_i,
	input logic                    resetn_i,
	input logic [1:0]              select_i,
	input logic [`PERF_WORD_W-1:0] comm_word_i,
	input logic                    stall_i
);

	// only the sampler bank may report a full table
	stall_needs_sampler: assert property (@(posedge clock_i) disable iff (!resetn_i)
		(select_i != 2'b01) |-> !stall_i)
		else $error("stall_o high while the sampler bank is not selected");

	// readout register clears on a reset edge
	comm_cleared_by_reset: assert property (@(posedge clock_i)
		!resetn_i |=> (comm_word_i == '0))
		else $error("comm_o not zero in the cycle after reset");

	stall_known: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!$isunknown(stall_i))
		else $error("stall_o is unknown out of reset");

endmodule

//--- tests/tb_cache_perf_monitor.sv
`timescale 1ns/100ps
`include "perf_settings.svh"

module tb_cache_perf_monitor;

	localparam int D = `PERF_SAMPLE_DEPTH;
	// reset, 400 random event cycles, two 60 request streams, fill, at most 200 reads of 2 cycles
	localparam int STIM_CYCLES    = 4 + 400 + 120 + 10 + 2 * 200;
	localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;
	// model counter behind each stats address pair or -1 when the pair is unmapped
	localparam int PAIR_CTR [11] = '{0, 1, 2, 9, 3, 5, 4, -1, 8, 6, 7};

	logic        clock;
	logic        resetn;
	logic [7:0]  ev;	// swap, rand_evict, defaulted, expired_multi, expired, writeback, miss, hit
	logic        req;
	logic [31:0] pc;
	logic [31:0] phase;
	logic [19:0] tag;
	logic [31:0] comm;
	logic [1:0]  sel;
	logic [3:0]  rate;
	logic [31:0] comm_o;
	logic        stall;
	int          cycle_count = 0;
	int          chk_seq = 0;	// read requests issued
	int          chk_done = 0;	// read requests compared
	logic [31:0] chk_exp;
	string       chk_name;
	// reference model state with counters in event index order
	logic [63:0] m_ctr [10];
	logic        m_swap;
	logic        m_valid [D];
	logic [19:0] m_tag [D];
	logic [31:0] m_pc [D];
	logic [31:0] m_stamp [D];
	logic [31:0] m_req_count;
	logic [31:0] m_interval;
	logic [31:0] m_last_pc;
	logic [31:0] m_measured;

	tb_clock_gen i_tb_clock_gen (
		.clock_o  (clock),
		.resetn_o (resetn)
	);

	cache_perf_monitor i_cache_perf_monitor (
		.clock_i         (clock),
		.resetn_i        (resetn),
		.hit_i           (ev[0]),
		.miss_i          (ev[1]),
		.writeback_i     (ev[2]),
		.expired_i       (ev[3]),
		.expired_multi_i (ev[4]),
		.defaulted_i     (ev[5]),
		.rand_evict_i    (ev[6]),
		.swap_i          (ev[7]),
		.req_i           (req),
		.pc_i            (pc),
		.phase_i         (phase),
		.tag_i           (tag),
		.comm_i          (comm),
		.select_i        (sel),
		.rate_i          (rate),
		.comm_o          (comm_o),
		.stall_o         (stall)
	);

	bind cache_perf_monitor perf_assertions i_perf_assertions (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.select_i    (select_i),
		.comm_word_i (comm_o),
		.stall_i     (stall_o)
	);

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic int model_occupancy();
		int n;
		n = 0;
		for (int i = 0; i < D; i++) n += int'(m_valid[i]);
		return n;
	endfunction

	// advance the model over the rising edge that samples the current inputs
	function automatic void model_step();
		int hit_slot;
		int free_slot;
		hit_slot  = -1;
		free_slot = -1;
		if (comm[`PERF_COUNT_EN_BIT]) begin
			for (int i = 0; i < 7; i++) m_ctr[i] += 64'(ev[i]);
			m_ctr[7] += 64'(ev[1] & ev[5]);	// miss on a defaulted lease
			m_ctr[8] += 64'(m_swap & ~ev[7]);	// swap fell since the last enabled edge
			m_ctr[9] += 64'd1;
			m_swap = ev[7];
		end
		if (sel == 2'b01 && req) begin
			for (int i = 0; i < D; i++) begin
				if (hit_slot < 0 && m_valid[i] && m_tag[i] == tag) hit_slot = i;
				if (free_slot < 0 && !m_valid[i]) free_slot = i;
			end
			if (hit_slot >= 0) begin
				m_valid[hit_slot] = 1'b0;
				m_interval        = m_req_count - m_stamp[hit_slot];
				m_last_pc         = m_pc[hit_slot];
				m_measured++;
			end else if ((m_req_count & ((32'd1 << rate) - 32'd1)) == 0 && free_slot >= 0) begin
				m_valid[free_slot] = 1'b1;
				m_tag[free_slot]   = tag;
				m_pc[free_slot]    = {phase[7:0], pc[23:0]};
				m_stamp[free_slot] = m_req_count;
			end
			m_req_count++;
		end
	endfunction

	// expected comm_o for a bank select and read address
	function automatic logic [31:0] model_read(input logic [1:0] s, input logic [4:0] a);
		logic [63:0] c;
		logic [31:0] w;
		int          occ;
		occ = model_occupancy();
		w   = '0;
		if (s == 2'b00 && a == 5'd15) begin
			w = `PERF_CACHE_ID;
		end else if (s == 2'b00 && a < 5'd22 && PAIR_CTR[a[4:1]] >= 0) begin
			c = m_ctr[PAIR_CTR[a[4:1]]];
			w = a[0] ? c[63:32] : c[31:0];	// high word at the odd address
		end else if (s == 2'b01) begin
			case (a)
				5'd0:    w = m_interval;
				5'd1:    w = m_last_pc;
				5'd2:    w = m_measured;
				5'd3:    w = 32'(occ);
				5'd4:    w = 32'(occ == D);
				5'd5:    w = m_req_count;
				default: w = '0;
			endcase
		end
		return w;
	endfunction

	task automatic apply_cycle();
		model_step();
		@(negedge clock);
		check_value("stall_o", 32'(stall), 32'(sel == 2'b01 && model_occupancy() == D));
	endtask

	task automatic read_word(input logic [1:0] s, input logic [4:0] a);
		comm     = {27'b0, a};	// counting frozen
		sel      = s;
		req      = 1'b0;
		chk_exp  = model_read(s, a);
		chk_name = $sformatf("comm_o[sel %0d addr %0d]", s, a);
		chk_seq++;
		wait (chk_done == chk_seq);
	endtask

	task automatic read_bank(input logic [1:0] s, input int last);
		for (int a = 0; a <= last; a++) read_word(s, 5'(a));
	endtask

	task automatic random_events(input int n, input logic en);
		for (int i = 0; i < n; i++) begin
			ev   = 8'($urandom);
			req  = 1'($urandom);	// sampler stays off, so requests are ignored
			sel  = $urandom_range(1, 0) ? 2'b10 : 2'b00;
			comm = {7'b0, en, 19'b0, 5'($urandom)};
			apply_cycle();
		end
	endtask

	task automatic sample_stream(input logic [3:0] r, input int n);
		for (int i = 0; i < n; i++) begin
			sel   = 2'b01;
			rate  = r;
			comm  = '0;
			ev    = '0;
			req   = ($urandom_range(3, 0) != 0);
			tag   = 20'h100 + 20'($urandom_range(5, 0));	// few tags give many reuses
			pc    = $urandom;
			phase = $urandom;
			apply_cycle();
		end
	endtask

	// compares comm_o two edges after each read address
	always begin
		wait (chk_done != chk_seq);
		repeat (2) @(posedge clock);
		@(negedge clock);
		check_value(chk_name, comm_o, chk_exp);
		chk_done = chk_seq;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$fatal(1, "timeout");
		end
	end

	initial begin
		void'($urandom(32'hd99d_edf1));
		for (int i = 0; i < 10; i++) m_ctr[i] = '0;
		for (int i = 0; i < D; i++) m_valid[i] = 1'b0;
		m_swap      = 1'b0;
		m_req_count = '0;
		m_interval  = '0;
		m_last_pc   = '0;
		m_measured  = '0;
		ev    = '0;
		req   = 1'b0;
		pc    = '0;
		phase = '0;
		tag   = '0;
		comm  = '0;
		sel   = 2'b00;
		rate  = '0;
		@(posedge resetn);
		@(negedge clock);
		read_bank(2'b00, 31);	// everything zero except the cache id
		read_bank(2'b01, 31);
		random_events(300, 1'b1);
		read_bank(2'b00, 21);
		random_events(100, 1'b0);	// counters must hold
		read_bank(2'b00, 21);
		sample_stream(4'd0, 60);
		read_bank(2'b01, 5);
		sample_stream(4'd2, 60);
		read_bank(2'b01, 5);
		// fill the table with new tags until stall rises
		sel  = 2'b01;
		rate = 4'd0;
		req  = 1'b1;
		for (int k = 0; k < 8 && model_occupancy() < D; k++) begin
			tag   = 20'hf0000 + 20'(k);
			pc    = $urandom;
			phase = $urandom;
			apply_cycle();
		end
		check_value("stall_o", 32'(stall), 32'd1);
		tag = 20'hf00ff;	// misses a full table and is not stored
		apply_cycle();
		read_bank(2'b01, 5);
		read_bank(2'b10, 15);
		check_value("stall_o", 32'(stall), 32'd0);
		read_bank(2'b11, 15);
		check_value("stall_o", 32'(stall), 32'd0);
		sel = 2'b01;
		req = 1'b1;
		tag = m_tag[2];	// reuse frees a slot
		apply_cycle();
		check_value("stall_o", 32'(stall), 32'd0);
		read_bank(2'b01, 5);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- list.f
+incdir+hdl
hdl/perf_pkg.sv
hdl/perf_cmd_decode.sv
hdl/perf_event_counters.sv
hdl/reuse_sampler.sv
hdl/perf_readout.sv
hdl/cache_perf_monitor.sv
tests/tb_clock_gen.sv
tests/perf_assertions.sv
tests/tb_cache_perf_monitor.sv

//--- Makefile
TOP := tb_cache_perf_monitor

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module $(TOP) -f list.f -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		--top-module cache_perf_monitor -f list.f

clean:
	rm -rf obj_dir
